//--- sim.f
+incdir+design
design/stk_pkg.sv
design/stk_pipe_ad.sv
design/stk_pipe_al.sv
design/stk_pipe_lk.sv
design/stk_pipe.sv
verification/stk_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the shared-stack testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module stk_tb -Mdir "$build_dir" -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vstk_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$log_file"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $log_file"
  exit 1
fi

//--- verification/stk_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "stk_consts.svh"

module stk_tb;

  import stk_pkg::*;

  // Watchdog budget counts the commands of every test plus the final drain and refill
  localparam int CMDS_ALL = 16 + 40 + 40 + 60 + 200 + 100 + 20;
  localparam int WDOG_CYC = CMDS_ALL * 8 + `STK_SLOTS_N + 3 + 64;

  logic                                    clk;
  logic                                    i_rst;
  logic [`STK_ENGS_N-1:0]                  i_cmd_vld;
  opcode_t [`STK_ENGS_N-1:0]               i_cmd_opcode;
  logic [`STK_ENGS_N-1:0][`STK_DAT_W-1:0]  i_cmd_dat;
  logic [`STK_ENGS_N-1:0]                  o_cmd_rdy;
  logic                                    o_rsp_vld;
  rsp_t                                    o_rsp;
  logic                                    i_rsp_rdy;

  // Traffic shape is changed by the test sequence on the falling edge
  int                      seed;
  logic [`STK_ENGS_N-1:0]  eng_mask;
  int unsigned             vld_pct;
  int unsigned             push_pct;
  int unsigned             rdy_pct;
  logic                    alt_ops;
  opcode_t                 last_op [`STK_ENGS_N];

  // Reference model of the stacks and the pool
  logic [`STK_DAT_W-1:0]   model_mem [`STK_ENGS_N][`STK_SLOTS_N];
  int                      model_depth [`STK_ENGS_N];
  int                      model_free;
  logic                    pop_from_full;
  rsp_t                    exp_q [$];

  // Monitor state and bookkeeping
  engid_t  last_gnt;
  int      init_cyc;
  logic    stall_q;
  rsp_t    held_rsp;
  int      acc_cnt;
  int      rsp_cnt;
  int      err_cnt;
  int      full_seen;
  int      empty_seen;
  int      push_after_pop;
  int      test_num;
  int      test_acc0;
  int      test_err0;

  stk_pipe stk_pipe_inst (
    .clk          (clk)
  , .i_rst        (i_rst)
  , .i_cmd_vld    (i_cmd_vld)
  , .i_cmd_opcode (i_cmd_opcode)
  , .i_cmd_dat    (i_cmd_dat)
  , .o_cmd_rdy    (o_cmd_rdy)
  , .o_rsp_vld    (o_rsp_vld)
  , .o_rsp        (o_rsp)
  , .i_rsp_rdy    (i_rsp_rdy)
  );

  always #10 clk = ~clk;

  function automatic logic chance(input int unsigned pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic logic [`STK_DAT_W-1:0] rand_word();
    logic [`STK_DAT_W-1:0] w;
    for (int k = 0; k < `STK_DAT_W / 32; k++) begin
      w[k*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  task automatic check_rsp(input string what, input rsp_t exp, input rsp_t got);
    if (exp.engid !== got.engid) begin
      $display("mismatch %s.engid exp %h got %h", what, exp.engid, got.engid);
      err_cnt++;
    end
    if (exp.opcode !== got.opcode) begin
      $display("mismatch %s.opcode exp %h got %h", what, exp.opcode, got.opcode);
      err_cnt++;
    end
    if (exp.status !== got.status) begin
      $display("mismatch %s.status exp %h got %h", what, exp.status, got.status);
      err_cnt++;
    end
    if (exp.dat !== got.dat) begin
      $display("mismatch %s.dat exp %h got %h", what, exp.dat, got.dat);
      err_cnt++;
    end
  endtask

  task automatic check_grant(input engid_t exp, input engid_t got);
    if (exp !== got) begin
      $display("mismatch o_cmd_rdy grant exp %h got %h", exp, got);
      err_cnt++;
    end
  endtask

  // Applies one accepted command to the model and queues the response it must give
  task automatic model_exec(input engid_t e, input opcode_t op, input logic [`STK_DAT_W-1:0] d);
    rsp_t r;
    r.engid = e;
    r.opcode = op;
    r.status = ST_OK;
    r.dat = '0;
    if (op == OP_PUSH) begin
      if (model_free == 0) begin
        r.status = ST_FULL;
      end else begin
        model_mem[e][model_depth[e]] = d;
        model_depth[e]++;
        model_free--;
        // A push that only succeeds thanks to the pop right before it
        if (pop_from_full) push_after_pop++;
      end
      pop_from_full = 1'b0;
    end else if (model_depth[e] == 0) begin
      r.status = ST_EMPTY;
      pop_from_full = 1'b0;
    end else begin
      pop_from_full = (model_free == 0);
      model_depth[e]--;
      r.dat = model_mem[e][model_depth[e]];
      model_free++;
    end
    exp_q.push_back(r);
  endtask

  // Each engine keeps its command until the handshake, then maybe picks a new one
  always @(posedge clk) begin : driver
    opcode_t op;
    for (int e = 0; e < `STK_ENGS_N; e++) begin
      if (!i_cmd_vld[e] || o_cmd_rdy[e]) begin
        if (eng_mask[e] && chance(vld_pct)) begin
          if (alt_ops) begin
            op = (last_op[e] == OP_PUSH) ? OP_POP : OP_PUSH;
          end else begin
            op = chance(push_pct) ? OP_PUSH : OP_POP;
          end
          last_op[e] = op;
          i_cmd_vld[e] <= 1'b1;
          i_cmd_opcode[e] <= op;
          i_cmd_dat[e] <= rand_word();
        end else begin
          i_cmd_vld[e] <= 1'b0;
        end
      end
    end
    i_rsp_rdy <= chance(rdy_pct);
  end

  // Watches both handshakes; all values read here are the ones before the edge
  always @(posedge clk) begin : monitor
    int exp_e;
    int got_e;
    rsp_t exp_rsp;
    if (i_rst) begin
      last_gnt = engid_t'(`STK_ENGS_N - 1);
      init_cyc = 0;
      stall_q = 1'b0;
    end else begin
      if (o_cmd_rdy != '0) begin
        if (init_cyc < `STK_SLOTS_N) begin
          $display("error: a command was granted while the free list was still filling");
          err_cnt++;
        end
        if ($countones(o_cmd_rdy) != 1) begin
          $display("error: more than one engine was granted in the same cycle");
          err_cnt++;
        end
        // The expected grant is the first valid engine after the last one granted
        exp_e = -1;
        got_e = 0;
        for (int i = 1; i <= `STK_ENGS_N; i++) begin
          if (exp_e < 0 && i_cmd_vld[(int'(last_gnt) + i) % `STK_ENGS_N]) begin
            exp_e = (int'(last_gnt) + i) % `STK_ENGS_N;
          end
        end
        for (int e = 0; e < `STK_ENGS_N; e++) begin
          if (o_cmd_rdy[e]) got_e = e;
        end
        if (exp_e < 0) begin
          $display("error: ready was raised although no engine had a valid command");
          err_cnt++;
        end else begin
          check_grant(engid_t'(exp_e), engid_t'(got_e));
        end
        last_gnt = engid_t'(got_e);
        if (i_cmd_vld[got_e]) begin
          model_exec(engid_t'(got_e), i_cmd_opcode[got_e], i_cmd_dat[got_e]);
          acc_cnt++;
        end
      end
      if (init_cyc < `STK_SLOTS_N) init_cyc++;

      // A stalled response must stay put until it leaves
      if (stall_q) begin
        if (!o_rsp_vld) begin
          $display("error: o_rsp_vld dropped while the response was stalled");
          err_cnt++;
        end else begin
          check_rsp("o_rsp held", held_rsp, o_rsp);
        end
      end
      if (o_rsp_vld && i_rsp_rdy) begin
        if (exp_q.size() == 0) begin
          $display("error: a response arrived with no command outstanding");
          err_cnt++;
        end else begin
          exp_rsp = exp_q.pop_front();
          check_rsp("o_rsp", exp_rsp, o_rsp);
          if (o_rsp.status == ST_FULL) full_seen++;
          if (o_rsp.status == ST_EMPTY) empty_seen++;
          rsp_cnt++;
        end
      end
      stall_q = o_rsp_vld && !i_rsp_rdy;
      held_rsp = o_rsp;
    end
  end

  task automatic set_traffic(input logic [`STK_ENGS_N-1:0] mask, input int unsigned vld,
                             input int unsigned push, input int unsigned rdy, input logic alt);
    eng_mask = mask;
    vld_pct = vld;
    push_pct = push;
    rdy_pct = rdy;
    alt_ops = alt;
  endtask

  // Stops new commands and waits until every accepted one has answered
  task automatic wait_idle();
    vld_pct = 0;
    rdy_pct = 100;
    do begin
      @(negedge clk);
    end while (i_cmd_vld != '0 || exp_q.size() != 0);
  endtask

  task automatic run_phase(input int n);
    int start;
    start = acc_cnt;
    while (acc_cnt < start + n) begin
      @(negedge clk);
    end
    wait_idle();
  endtask

  task automatic close_test(input string name);
    test_num++;
    $display("test %0d %s: %0d commands, %0d errors", test_num, name,
             acc_cnt - test_acc0, err_cnt - test_err0);
    test_acc0 = acc_cnt;
    test_err0 = err_cnt;
  endtask

  initial begin : watchdog
    repeat (WDOG_CYC) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WDOG_CYC);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : run_tests
    clk = 1'b0;
    i_rst = 1'b1;
    i_cmd_vld = '0;
    i_cmd_dat = '0;
    i_rsp_rdy = 1'b0;
    seed = 32'h675c_cba5;
    model_free = `STK_SLOTS_N;
    pop_from_full = 1'b0;
    {acc_cnt, rsp_cnt, err_cnt, full_seen, empty_seen} = '0;
    {push_after_pop, test_num, test_acc0, test_err0} = '0;
    for (int e = 0; e < `STK_ENGS_N; e++) begin
      i_cmd_opcode[e] = OP_PUSH;
      last_op[e] = OP_PUSH;
      model_depth[e] = 0;
    end
    set_traffic('0, 0, 0, 100, 1'b0);
    repeat (3) @(posedge clk);
    i_rst <= 1'b0;
    @(negedge clk);

    // Pushes wait out the free-list fill, then come back in LIFO order
    set_traffic(4'b0001, 100, 100, 100, 1'b0);
    run_phase(8);
    set_traffic(4'b0001, 100, 0, 100, 1'b0);
    run_phase(8);
    close_test("push then pop");

    // Empty pops, an overfilled pool, then pop and push pairs on a full pool
    set_traffic(4'b0010, 100, 0, 100, 1'b0);
    run_phase(4);
    set_traffic(4'b1111, 100, 100, 100, 1'b0);
    run_phase(24);
    set_traffic(4'b0001, 100, 0, 100, 1'b1);
    run_phase(12);
    if (empty_seen == 0 || full_seen == 0) begin
      $display("error: the stack limit test never saw both an empty and a full status");
      err_cnt++;
    end
    if (push_after_pop == 0) begin
      $display("error: no push ever reused a slot freed by the pop just before it");
      err_cnt++;
    end
    close_test("stack limits");

    set_traffic(4'b1111, 100, 50, 100, 1'b0);
    run_phase(40);
    close_test("arbitration");

    set_traffic(4'b1111, 70, 50, 50, 1'b0);
    run_phase(60);
    close_test("back-pressure");

    set_traffic(4'b1111, 80, 55, 80, 1'b0);
    run_phase(200);
    // Pop everything so the whole pool comes back
    set_traffic(4'b1111, 100, 0, 100, 1'b0);
    while (model_free != `STK_SLOTS_N) begin
      @(negedge clk);
    end
    wait_idle();
    // Refill the whole pool, which only succeeds if the drain returned every slot
    set_traffic(4'b1111, 100, 100, 100, 1'b0);
    run_phase(`STK_SLOTS_N);
    close_test("random mix");

    $display("tests %0d, commands %0d, responses %0d, errors %0d",
             test_num, acc_cnt, rsp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : stk_tb

`default_nettype wire

//--- design/stk_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "stk_consts.svh"

module stk_pipe (
  input wire logic                                    clk
, input wire logic                                    i_rst
//
, input wire logic [`STK_ENGS_N-1:0]                  i_cmd_vld
, input wire stk_pkg::opcode_t [`STK_ENGS_N-1:0]      i_cmd_opcode
, input wire logic [`STK_ENGS_N-1:0][`STK_DAT_W-1:0]  i_cmd_dat
, output wire logic [`STK_ENGS_N-1:0]                 o_cmd_rdy
//
, output wire logic                                   o_rsp_vld
, output wire stk_pkg::rsp_t                          o_rsp
, input wire logic                                    i_rsp_rdy
);

  import stk_pkg::*;

  // Admission and allocator handshake
  logic     al_busy;
  logic     al_empty;
  logic     ad_alloc_req;
  ptr_t     al_ptr;

  // Stage register from admission into link
  logic     lk_vld;
  lk_cmd_t  lk_cmd;
  logic     lk_rdy;

  // Slots returned by successful pops
  logic     dealloc_vld;
  ptr_t     dealloc_ptr;

  // Arbitration, full check and the command register
  stk_pipe_ad u_stk_pipe_ad (
    .clk              (clk)
  , .i_rst            (i_rst)
  , .i_cmd_vld        (i_cmd_vld)
  , .i_cmd_opcode     (i_cmd_opcode)
  , .i_cmd_dat        (i_cmd_dat)
  , .o_cmd_rdy        (o_cmd_rdy)
  , .i_al_busy        (al_busy)
  , .i_al_empty       (al_empty)
  , .o_al_alloc_req   (ad_alloc_req)
  , .i_al_ptr         (al_ptr)
  , .o_lk_vld         (lk_vld)
  , .o_lk_cmd         (lk_cmd)
  , .i_lk_rdy         (lk_rdy)
  );

  // Free list of pool slots
  stk_pipe_al u_stk_pipe_al (
    .clk              (clk)
  , .i_rst            (i_rst)
  , .i_alloc_req      (ad_alloc_req)
  , .o_busy           (al_busy)
  , .o_empty          (al_empty)
  , .o_alloc_ptr      (al_ptr)
  , .i_dealloc_vld    (dealloc_vld)
  , .i_dealloc_ptr    (dealloc_ptr)
  );

  // Head table, slot memory and the response register
  stk_pipe_lk u_stk_pipe_lk (
    .clk              (clk)
  , .i_rst            (i_rst)
  , .i_lk_vld         (lk_vld)
  , .i_lk_cmd         (lk_cmd)
  , .o_lk_rdy         (lk_rdy)
  , .o_dealloc_vld    (dealloc_vld)
  , .o_dealloc_ptr    (dealloc_ptr)
  , .o_rsp_vld        (o_rsp_vld)
  , .o_rsp            (o_rsp)
  , .i_rsp_rdy        (i_rsp_rdy)
  );

endmodule : stk_pipe

`default_nettype wire

//--- design/stk_pipe_lk.sv
`timescale 1ns/10ps
`default_nettype none

`include "stk_consts.svh"

module stk_pipe_lk (
  input wire logic                clk
, input wire logic                i_rst
//
, input wire logic                i_lk_vld
, input wire stk_pkg::lk_cmd_t    i_lk_cmd
, output wire logic               o_lk_rdy
//
, output wire logic               o_dealloc_vld
, output wire stk_pkg::ptr_t      o_dealloc_ptr
//
, output wire logic               o_rsp_vld
, output wire stk_pkg::rsp_t      o_rsp
, input wire logic                i_rsp_rdy
);

  import stk_pkg::*;

  // Per-engine head of stack
  ptr_t                   head_q [`STK_ENGS_N];
  logic [`STK_ENGS_N-1:0] head_vld_q;

  // Slot memory holding the data word and the link to the entry below it
  logic [`STK_DAT_W-1:0]  dat_mem_q [`STK_SLOTS_N];
  ptr_t                   link_mem_q [`STK_SLOTS_N];
  logic                   link_vld_mem_q [`STK_SLOTS_N];

  logic                   rsp_vld_q;
  rsp_t                   rsp_q;
  rsp_t                   rsp_d;

  logic                   exec;
  logic                   is_push;
  ptr_t                   cur_head;
  logic                   cur_vld;
  logic                   push_ok;
  logic                   pop_ok;

  // The response register takes a new entry when empty or when it is leaving
  assign o_lk_rdy = ~rsp_vld_q | i_rsp_rdy;

  // A command executes only on the cycle it moves into the response register
  assign exec = i_lk_vld & o_lk_rdy;

  assign is_push = (i_lk_cmd.opcode == OP_PUSH);

  assign cur_head = head_q[i_lk_cmd.engid];
  assign cur_vld = head_vld_q[i_lk_cmd.engid];

  assign push_ok = exec & is_push & ~i_lk_cmd.full;
  assign pop_ok = exec & ~is_push & cur_vld;

  // The popped head slot goes back to the allocator in the same cycle
  assign o_dealloc_vld = pop_ok;
  assign o_dealloc_ptr = cur_head;

  always_comb begin
    rsp_d.engid = i_lk_cmd.engid;
    rsp_d.opcode = i_lk_cmd.opcode;
    rsp_d.status = ST_OK;
    rsp_d.dat = '0;
    if (is_push) begin
      if (i_lk_cmd.full) begin
        rsp_d.status = ST_FULL;
      end
    end else if (!cur_vld) begin
      rsp_d.status = ST_EMPTY;
    end else begin
      rsp_d.dat = dat_mem_q[cur_head];
    end
  end

  // New entry points down at the old head, or at nothing for an empty stack
  always_ff @(posedge clk) begin
    if (push_ok) begin
      dat_mem_q[i_lk_cmd.ptr] <= i_lk_cmd.dat;
      link_mem_q[i_lk_cmd.ptr] <= cur_head;
      link_vld_mem_q[i_lk_cmd.ptr] <= cur_vld;
    end
  end

  // The head moves to the new slot on a push and down the link on a pop
  always_ff @(posedge clk) begin
    if (push_ok) begin
      head_q[i_lk_cmd.engid] <= i_lk_cmd.ptr;
    end else if (pop_ok) begin
      head_q[i_lk_cmd.engid] <= link_mem_q[cur_head];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      head_vld_q <= '0;
    end else if (push_ok) begin
      head_vld_q[i_lk_cmd.engid] <= 1'b1;
    end else if (pop_ok) begin
      // The stack empties when the popped entry had no link below it
      head_vld_q[i_lk_cmd.engid] <= link_vld_mem_q[cur_head];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rsp_vld_q <= 1'b0;
    end else if (o_lk_rdy) begin
      rsp_vld_q <= i_lk_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      rsp_q <= rsp_d;
    end
  end

  assign o_rsp_vld = rsp_vld_q;
  assign o_rsp = rsp_q;

  // A slot is only returned to the pool by an engine that really holds one
  a_dealloc_head: assert property (@(posedge clk) disable iff (i_rst)
    o_dealloc_vld |-> head_vld_q[i_lk_cmd.engid]);

endmodule : stk_pipe_lk

`default_nettype wire

//--- design/stk_pipe_al.sv
`timescale 1ns/10ps
`default_nettype none

`include "stk_consts.svh"

module stk_pipe_al (
  input wire logic                clk
, input wire logic                i_rst
//
, input wire logic                i_alloc_req
, output wire logic               o_busy
, output wire logic               o_empty
, output wire stk_pkg::ptr_t      o_alloc_ptr
//
, input wire logic                i_dealloc_vld
, input wire stk_pkg::ptr_t       i_dealloc_ptr
);

  import stk_pkg::*;

  ptr_t   mem_q [`STK_SLOTS_N];
  ptr_t   rd_ptr_q;
  ptr_t   wr_ptr_q;
  cnt_t   count_q;
  logic   busy_q;
  logic   fifo_empty;
  logic   bypass;
  logic   pop;
  logic   push;
  logic   wr_en;
  ptr_t   wr_dat;

  assign fifo_empty = (count_q == '0);

  // A slot freed this cycle can be handed straight to a push
  assign bypass = fifo_empty & i_dealloc_vld;

  assign o_busy = busy_q;
  assign o_empty = fifo_empty & ~i_dealloc_vld;
  assign o_alloc_ptr = bypass ? i_dealloc_ptr : mem_q[rd_ptr_q];

  // When the bypass is taken the freed slot never enters the FIFO
  assign pop = i_alloc_req & ~bypass;
  assign push = i_dealloc_vld & ~(bypass & i_alloc_req);

  // During initialisation each slot writes its own index
  assign wr_en = busy_q | push;
  assign wr_dat = busy_q ? wr_ptr_q : i_dealloc_ptr;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy_q <= 1'b1;
      count_q <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      if (busy_q) begin
        count_q <= count_q + cnt_t'(1);
        // The last slot goes in on this cycle
        if (count_q == cnt_t'(`STK_SLOTS_N - 1)) begin
          busy_q <= 1'b0;
        end
      end else begin
        count_q <= count_q + cnt_t'(push) - cnt_t'(pop);
      end
    end
  end

  // Admission must never ask for a slot the pool does not have
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (i_rst)
    !(i_alloc_req && o_empty));

  a_count_bound: assert property (@(posedge clk) disable iff (i_rst)
    count_q <= cnt_t'(`STK_SLOTS_N));

endmodule : stk_pipe_al

`default_nettype wire

//--- design/stk_pipe_ad.sv
`timescale 1ns/10ps
`default_nettype none

`include "stk_consts.svh"

module stk_pipe_ad (
  input wire logic                                    clk
, input wire logic                                    i_rst
//
, input wire logic [`STK_ENGS_N-1:0]                  i_cmd_vld
, input wire stk_pkg::opcode_t [`STK_ENGS_N-1:0]      i_cmd_opcode
, input wire logic [`STK_ENGS_N-1:0][`STK_DAT_W-1:0]  i_cmd_dat
, output wire logic [`STK_ENGS_N-1:0]                 o_cmd_rdy
//
, input wire logic                                    i_al_busy
, input wire logic                                    i_al_empty
, output wire logic                                   o_al_alloc_req
, input wire stk_pkg::ptr_t                           i_al_ptr
//
, output wire logic                                   o_lk_vld
, output wire stk_pkg::lk_cmd_t                       o_lk_cmd
, input wire logic                                    i_lk_rdy
);

  import stk_pkg::*;

  engid_t   rr_q;
  logic     gnt_vld;
  engid_t   gnt_id;
  logic     load_en;
  logic     fire;
  logic     is_push;
  logic     lk_vld_q;
  lk_cmd_t  lk_cmd_q;
  lk_cmd_t  lk_cmd_d;

  // The stage register can take a new command when it is empty or draining into lk
  assign load_en = ~lk_vld_q | i_lk_rdy;

  // Search the engines starting just after the one granted last
  always_comb begin : rr_pick
    int idx;
    gnt_vld = 1'b0;
    gnt_id = '0;
    for (int i = 1; i <= `STK_ENGS_N; i++) begin
      idx = (int'(rr_q) + i) % `STK_ENGS_N;
      if (~gnt_vld && i_cmd_vld[idx]) begin
        gnt_vld = 1'b1;
        gnt_id = engid_t'(idx);
      end
    end
  end

  // No grant while the allocator is still filling its free list
  assign fire = gnt_vld & ~i_al_busy & load_en;

  assign o_cmd_rdy = fire ? ({{(`STK_ENGS_N-1){1'b0}}, 1'b1} << gnt_id) : '0;

  assign is_push = (i_cmd_opcode[gnt_id] == OP_PUSH);

  // Only a push that sees a free slot takes one from the allocator
  assign o_al_alloc_req = fire & is_push & ~i_al_empty;

  always_comb begin
    lk_cmd_d.engid = gnt_id;
    lk_cmd_d.opcode = i_cmd_opcode[gnt_id];
    lk_cmd_d.dat = i_cmd_dat[gnt_id];
    lk_cmd_d.ptr = i_al_ptr;
    // A push against an exhausted pool is marked here and completes with ST_FULL later
    lk_cmd_d.full = is_push & i_al_empty;
  end

  // Start the rotation so that engine 0 is first after reset
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rr_q <= engid_t'(`STK_ENGS_N - 1);
      lk_vld_q <= 1'b0;
    end else begin
      if (fire) begin
        rr_q <= gnt_id;
      end
      if (load_en) begin
        lk_vld_q <= fire;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      lk_cmd_q <= lk_cmd_d;
    end
  end

  assign o_lk_vld = lk_vld_q;
  assign o_lk_cmd = lk_cmd_q;

  // At most one engine sees ready in any cycle
  a_rdy_onehot: assert property (@(posedge clk) disable iff (i_rst)
    $onehot0(o_cmd_rdy));

endmodule : stk_pipe_ad

`default_nettype wire

//--- design/stk_pkg.sv
`default_nettype none

`include "stk_consts.svh"

package stk_pkg;

  // Index widths derived from the sizing macros
  localparam int ENGID_W = $clog2(`STK_ENGS_N);
  localparam int PTR_W = $clog2(`STK_SLOTS_N);

  // Engine index
  typedef logic [ENGID_W-1:0] engid_t;

  // Slot index into the common pool
  typedef logic [PTR_W-1:0] ptr_t;

  // Slot count, one bit wider so a completely free pool fits
  typedef logic [PTR_W:0] cnt_t;

  // Command opcode as presented by an engine
  typedef enum logic {
    OP_PUSH = 1'b0,
    OP_POP  = 1'b1
  } opcode_t;

  // Completion status returned with each response
  typedef enum logic [1:0] {
    ST_OK    = 2'd0,
    ST_FULL  = 2'd1,
    ST_EMPTY = 2'd2
  } status_t;

  // Command held in the stage register between admission and link
  // The ptr field is only meaningful for a push that found a free slot
  typedef struct packed {
    engid_t                 engid;
    opcode_t                opcode;
    logic [`STK_DAT_W-1:0]  dat;
    ptr_t                   ptr;
    logic                   full;
  } lk_cmd_t;

  // Response word, dat is zero unless a pop completed with ST_OK
  typedef struct packed {
    engid_t                 engid;
    opcode_t                opcode;
    status_t                status;
    logic [`STK_DAT_W-1:0]  dat;
  } rsp_t;

endpackage : stk_pkg

`default_nettype wire

//--- design/stk_consts.svh
`ifndef STK_CONSTS_SVH
`define STK_CONSTS_SVH

// Sizing of the shared-stack engine
// Every module and the package pick their widths up from here

// Number of client engines that own a private stack
`define STK_ENGS_N 4

// Number of storage slots in the common pool
// The free-list FIFO wraps its pointers naturally, so keep this a power of two
`define STK_SLOTS_N 16

// Width of the data word carried by every push and pop
`define STK_DAT_W 128

`endif
